//--- Bender.yml
package:
  name: zbt_sram_subsys

sources:
  # synthesizable subsystem
  - files:
      - logic/zbt_pkg.sv
      - logic/zbt_wb_bridge.sv
      - logic/zbt_sram_array.sv
      - logic/zbt_sram_subsys.sv

  # testbench, clock generator and bound checks
  - target: simulation
    files:
      - verif/tb_clock_gen.sv
      - verif/zbt_bridge_assertions.sv
      - verif/zbt_sram_subsys_tb.sv

//--- files.f
logic/zbt_pkg.sv
logic/zbt_wb_bridge.sv
logic/zbt_sram_array.sv
logic/zbt_sram_subsys.sv
verif/tb_clock_gen.sv
verif/zbt_bridge_assertions.sv
verif/zbt_sram_subsys_tb.sv

//--- logic/zbt_pkg.sv
package zbt_pkg;

  // wishbone side, byte address bits 19 down to 1 on the port
  localparam int WB_ADDR_W = 19;
  localparam int WB_DATA_W = 16;
  localparam int WB_SEL_W  = 2;

  // zbt pads
  localparam int SRAM_ADDR_W = 21;
  localparam int SRAM_DATA_W = 32;
  localparam int SRAM_BW_W   = 4;

  // reduced depth of the on-chip stand-in array
  localparam int ARRAY_AW    = 12;
  localparam int ARRAY_WORDS = 1 << ARRAY_AW;

  // edges from first sampled request to the edge raising ack, both counted
  localparam int ACK_LATENCY = 5;

  // bridge sequencer, one step per wishbone clock edge
  typedef enum logic [2:0] {
    PH_IDLE  = 3'd0,
    // address and enables launched
    PH_ADDR  = 3'd1,
    // sram pipeline stages
    PH_WAIT1 = 3'd2,
    PH_WAIT2 = 3'd3,
    // read word sampled into wb_dat_o
    PH_DATA  = 3'd4,
    // ack held until the master drops the request
    PH_ACK   = 3'd5
  } zbt_phase_e;

  // access kind
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } zbt_op_e;

endpackage

//--- logic/zbt_sram_array.sv
`timescale 1ns/10ps

module zbt_sram_array (
  input  logic                            sram_clk_i,
  input  logic                            arst_n_i,
  input  logic [zbt_pkg::SRAM_ADDR_W-1:0] sram_addr_i,
  inout  wire  [zbt_pkg::SRAM_DATA_W-1:0] sram_data_io,
  input  logic                            sram_we_n_i,
  input  logic                            sram_cen_i,
  input  logic                            sram_adv_ld_n_i,
  input  logic [zbt_pkg::SRAM_BW_W-1:0]   sram_bw_i
);
  import zbt_pkg::*;

  logic [SRAM_DATA_W-1:0] mem [ARRAY_WORDS];

  // command decode at the pins
  logic    cyc_en;
  zbt_op_e cyc_op;

  // pipeline stage 1
  logic                 s1_vld_q;
  zbt_op_e              s1_op_q;
  logic [ARRAY_AW-1:0]  s1_addr_q;
  logic [SRAM_BW_W-1:0] s1_bw_q;

  // pipeline stage 2
  logic                 s2_vld_q;
  zbt_op_e              s2_op_q;
  logic [ARRAY_AW-1:0]  s2_addr_q;
  logic [SRAM_BW_W-1:0] s2_bw_q;

  // read data output
  logic                   drv_en_q;
  logic [SRAM_DATA_W-1:0] drv_data_q;

  initial begin
    for (int i = 0; i < ARRAY_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // a cycle with no byte lane active is a dummy cycle
  assign cyc_en = !sram_cen_i && (sram_bw_i != '1);

  // no burst counter here, so an advance is taken as a fresh load from the pins
  assign cyc_op = sram_we_n_i ? OP_READ : OP_WRITE;

  always_ff @(posedge sram_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      s1_vld_q  <= 1'b0;
      s2_vld_q  <= 1'b0;
      drv_en_q  <= 1'b0;
    end else begin
      s1_vld_q <= cyc_en;
      s2_vld_q <= s1_vld_q;
      drv_en_q <= s2_vld_q && (s2_op_q == OP_READ);
    end
  end

  always_ff @(posedge sram_clk_i) begin
    s1_op_q   <= cyc_op;
    s1_addr_q <= sram_addr_i[ARRAY_AW-1:0];
    s1_bw_q   <= sram_bw_i;
    s2_op_q   <= s1_op_q;
    s2_addr_q <= s1_addr_q;
    s2_bw_q   <= s1_bw_q;
  end

  // second edge after the command stores write bytes or launches the read word
  always_ff @(posedge sram_clk_i) begin
    if (s2_vld_q && (s2_op_q == OP_WRITE)) begin
      for (int b = 0; b < SRAM_BW_W; b++) begin
        if (!s2_bw_q[b]) begin
          mem[s2_addr_q][8*b +: 8] <= sram_data_io[8*b +: 8];
        end
      end
    end
    drv_data_q <= mem[s2_addr_q];
  end

  assign sram_data_io = drv_en_q ? drv_data_q : 'z;

endmodule

//--- logic/zbt_sram_subsys.sv
`timescale 1ns/10ps

module zbt_sram_subsys (
  input  logic                          wb_clk_i,
  input  logic                          arst_n_i,
  input  logic [zbt_pkg::WB_DATA_W-1:0] wb_dat_i,
  output logic [zbt_pkg::WB_DATA_W-1:0] wb_dat_o,
  input  logic [zbt_pkg::WB_ADDR_W-1:0] wb_adr_i,
  input  logic                          wb_we_i,
  input  logic [zbt_pkg::WB_SEL_W-1:0]  wb_sel_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_cyc_i,
  output logic                          wb_ack_o
);
  import zbt_pkg::*;

  // pad nets between bridge and array
  logic                   sram_clk;
  logic [SRAM_ADDR_W-1:0] sram_addr;
  wire  [SRAM_DATA_W-1:0] sram_data;
  logic                   sram_we_n;
  logic [SRAM_BW_W-1:0]   sram_bw;
  logic                   sram_cen;
  logic                   sram_adv_ld_n;

  zbt_wb_bridge u_bridge (
    .wb_clk_i        (wb_clk_i),
    .arst_n_i        (arst_n_i),
    .wb_dat_i        (wb_dat_i),
    .wb_dat_o        (wb_dat_o),
    .wb_adr_i        (wb_adr_i),
    .wb_we_i         (wb_we_i),
    .wb_sel_i        (wb_sel_i),
    .wb_stb_i        (wb_stb_i),
    .wb_cyc_i        (wb_cyc_i),
    .wb_ack_o        (wb_ack_o),
    .sram_clk_o      (sram_clk),
    .sram_addr_o     (sram_addr),
    .sram_data_io    (sram_data),
    .sram_we_n_o     (sram_we_n),
    .sram_bw_o       (sram_bw),
    .sram_cen_o      (sram_cen),
    .sram_adv_ld_n_o (sram_adv_ld_n)
  );

  // stand-in for the external part
  zbt_sram_array u_array (
    .sram_clk_i      (sram_clk),
    .arst_n_i        (arst_n_i),
    .sram_addr_i     (sram_addr),
    .sram_data_io    (sram_data),
    .sram_we_n_i     (sram_we_n),
    .sram_cen_i      (sram_cen),
    .sram_adv_ld_n_i (sram_adv_ld_n),
    .sram_bw_i       (sram_bw)
  );

endmodule

//--- logic/zbt_wb_bridge.sv
`timescale 1ns/10ps

module zbt_wb_bridge (
  input  logic                            wb_clk_i,
  input  logic                            arst_n_i,
  input  logic [zbt_pkg::WB_DATA_W-1:0]   wb_dat_i,
  output logic [zbt_pkg::WB_DATA_W-1:0]   wb_dat_o,
  input  logic [zbt_pkg::WB_ADDR_W-1:0]   wb_adr_i,
  input  logic                            wb_we_i,
  input  logic [zbt_pkg::WB_SEL_W-1:0]    wb_sel_i,
  input  logic                            wb_stb_i,
  input  logic                            wb_cyc_i,
  output logic                            wb_ack_o,
  output logic                            sram_clk_o,
  output logic [zbt_pkg::SRAM_ADDR_W-1:0] sram_addr_o,
  inout  wire  [zbt_pkg::SRAM_DATA_W-1:0] sram_data_io,
  output logic                            sram_we_n_o,
  output logic [zbt_pkg::SRAM_BW_W-1:0]   sram_bw_o,
  output logic                            sram_cen_o,
  output logic                            sram_adv_ld_n_o
);
  import zbt_pkg::*;

  zbt_phase_e phase_q;
  zbt_phase_e phase_d;

  logic req;
  logic start;

  // captured request
  logic                   we_q;
  logic                   half_q;
  logic [SRAM_DATA_W-1:0] wr_data_q;
  logic [SRAM_BW_W-1:0]   lane_n_q;

  // a request is strobe and cycle together
  assign req   = wb_stb_i & wb_cyc_i;
  assign start = (phase_q == PH_IDLE) && req;

  // next phase
  always_comb begin
    phase_d = phase_q;
    unique case (phase_q)
      PH_IDLE: begin
        if (req) begin
          phase_d = PH_ADDR;
        end
      end
      PH_ADDR:  phase_d = PH_WAIT1;
      PH_WAIT1: phase_d = PH_WAIT2;
      PH_WAIT2: phase_d = PH_DATA;
      PH_DATA:  phase_d = PH_ACK;
      PH_ACK: begin
        // hold ack until the master lets go of the request
        if (!req) begin
          phase_d = PH_IDLE;
        end
      end
      default:  phase_d = PH_IDLE;
    endcase
  end

  always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      phase_q <= PH_IDLE;
      we_q    <= 1'b0;
    end else begin
      phase_q <= phase_d;
      if (start) begin
        we_q <= wb_we_i;
      end
    end
  end

  // address, write word and lane mask are latched once per request
  always_ff @(posedge wb_clk_i) begin
    if (start) begin
      // byte address >> 2 gives the 32-bit word
      sram_addr_o <= SRAM_ADDR_W'(wb_adr_i[WB_ADDR_W-1:1]);
      half_q      <= wb_adr_i[0];
      if (wb_adr_i[0]) begin
        wr_data_q <= {wb_dat_i, WB_DATA_W'(0)};
        lane_n_q  <= {~wb_sel_i, {WB_SEL_W{1'b1}}};
      end else begin
        wr_data_q <= {WB_DATA_W'(0), wb_dat_i};
        lane_n_q  <= {{WB_SEL_W{1'b1}}, ~wb_sel_i};
      end
    end
  end

  // read word is on the bus during PH_DATA, two sram edges after the command
  always_ff @(posedge wb_clk_i) begin
    if ((phase_q == PH_DATA) && !we_q) begin
      if (half_q) begin
        wb_dat_o <= sram_data_io[SRAM_DATA_W-1:WB_DATA_W];
      end else begin
        wb_dat_o <= sram_data_io[WB_DATA_W-1:0];
      end
    end
  end

  assign wb_ack_o = (phase_q == PH_ACK);

  // sram samples on the falling edge of wb_clk_i
  assign sram_clk_o = ~wb_clk_i;

  // no bursts, every cycle is a load
  assign sram_adv_ld_n_o = 1'b0;

  // chip enable low from PH_ADDR through PH_DATA
  assign sram_cen_o = (phase_q == PH_IDLE) || (phase_q == PH_ACK);

  assign sram_we_n_o = !((phase_q == PH_WAIT1) && we_q);

  // lanes are only active in the command phase:
  // selected bytes on a write, the whole word on a read
  always_comb begin
    if (phase_q == PH_WAIT1) begin
      sram_bw_o = we_q ? lane_n_q : '0;
    end else begin
      sram_bw_o = '1;
    end
  end

  // drive write data for the whole write cycle, never on reads
  assign sram_data_io = ((phase_q != PH_IDLE) && we_q) ? wr_data_q : 'z;

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 100 ns period
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // reset held low for the first 8 rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

//--- verif/zbt_bridge_assertions.sv
`timescale 1ns/10ps

module zbt_bridge_assertions (
  input logic                          clk_i,
  input logic                          arst_n_i,
  input logic                          stb_i,
  input logic                          cyc_i,
  input logic                          we_i,
  input logic [zbt_pkg::WB_ADDR_W-1:0] adr_i,
  input logic                          ack_i,
  input logic                          cen_n_i,
  input logic                          we_n_i
);

  logic req;

  assign req = stb_i & cyc_i;

  // ack may only rise while a request is pending
  ack_after_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(ack_i) |-> req)
    else $error("acknowledge rose without a pending request");

  // master keeps the request and its address until it is acknowledged
  req_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (req && !ack_i) |=> (req && $stable(adr_i) && $stable(we_i)))
    else $error("request changed before acknowledge");

  // no sram cycle may run while the bus is quiet
  cen_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !req |-> cen_n_i)
    else $error("sram chip enable active while no request is pending");

  // a read cycle must never pulse the sram write enable
  no_we_on_read: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (req && !we_i) |-> we_n_i)
    else $error("sram write enable low during a read cycle");

endmodule

//--- verif/zbt_sram_subsys_tb.sv
`timescale 1ns/10ps

module zbt_sram_subsys_tb;
  import zbt_pkg::*;

  localparam int N_DIR_WORDS = 4;
  localparam int N_RANDOM    = 300;
  // reset read, full-word pass, byte-lane pass, random pass
  localparam int N_TXN       = 1 + 2 * (4 * N_DIR_WORDS) + N_RANDOM;
  localparam int CYCLE_LIMIT = N_TXN * 8 + 200;
  localparam int REF_BYTES   = 2 * (1 << (ARRAY_AW + 1));

  typedef struct packed {
    zbt_op_e                op;
    logic [WB_ADDR_W-1:0]   adr;
    logic [WB_SEL_W-1:0]    sel;
    logic [WB_DATA_W-1:0]   wdat;
    logic [WB_DATA_W-1:0]   rdat;
    int                     lat;
  } txn_t;

  logic                 wb_clk;
  logic                 arst_n;
  logic [WB_DATA_W-1:0] wb_dat_i;
  logic [WB_DATA_W-1:0] wb_dat_o;
  logic [WB_ADDR_W-1:0] wb_adr;
  logic                 wb_we;
  logic [WB_SEL_W-1:0]  wb_sel;
  logic                 wb_stb;
  logic                 wb_cyc;
  logic                 wb_ack;

  logic [7:0]  ref_bytes [REF_BYTES];
  logic [31:0] rng_state = 32'hd4ef_b55e;
  txn_t        txn_q [$];
  string       name_q [$];
  string       test_name = "reset";
  int          cycle_cnt = 0;
  int          reads_issued = 0;
  int          reads_checked = 0;

  tb_clock_gen u_clk_gen (
    .clk_o   (wb_clk),
    .rst_n_o (arst_n)
  );

  zbt_sram_subsys uut (
    .wb_clk_i (wb_clk),
    .arst_n_i (arst_n),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_adr_i (wb_adr),
    .wb_we_i  (wb_we),
    .wb_sel_i (wb_sel),
    .wb_stb_i (wb_stb),
    .wb_cyc_i (wb_cyc),
    .wb_ack_o (wb_ack)
  );

  bind zbt_wb_bridge zbt_bridge_assertions u_bridge_assertions (
    .clk_i    (wb_clk_i),
    .arst_n_i (arst_n_i),
    .stb_i    (wb_stb_i),
    .cyc_i    (wb_cyc_i),
    .we_i     (wb_we_i),
    .adr_i    (wb_adr_i),
    .ack_i    (wb_ack_o),
    .cen_n_i  (sram_cen_o),
    .we_n_i   (sram_we_n_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  // byte index is twice the halfword address plus the lane
  function automatic logic [WB_DATA_W-1:0] ref_read(input logic [WB_ADDR_W-1:0] adr);
    int base;
    base = 2 * int'(adr[ARRAY_AW:0]);
    return {ref_bytes[base + 1], ref_bytes[base]};
  endfunction

  task automatic ref_write(input logic [WB_ADDR_W-1:0] adr, input logic [WB_SEL_W-1:0] sel,
                           input logic [WB_DATA_W-1:0] dat);
    int base;
    int i;
    base = 2 * int'(adr[ARRAY_AW:0]);
    for (i = 0; i < WB_SEL_W; i++) begin
      if (sel[i]) begin
        ref_bytes[base + i] = dat[8*i +: 8];
      end
    end
  endtask

  task automatic check_data(input string name, input logic [WB_DATA_W-1:0] exp,
                            input logic [WB_DATA_W-1:0] act);
    if (act !== exp) begin
      $display("Error in %s: read data expected 16'h%04h, actual 16'h%04h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("Error in %s: ack latency expected %0d, actual %0d", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic check_ack(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error in %s: wb_ack_o expected %b, actual %b", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // one classic cycle with edges counted from the one that samples the request
  task automatic run_bus_cycle(input zbt_op_e op, input logic [WB_ADDR_W-1:0] adr,
                               input logic [WB_SEL_W-1:0] sel,
                               input logic [WB_DATA_W-1:0] dat);
    txn_t t;
    int   edges;
    logic ack_seen;
    @(posedge wb_clk);
    wb_adr   <= adr;
    wb_sel   <= sel;
    wb_we    <= (op == OP_WRITE);
    wb_dat_i <= (op == OP_WRITE) ? dat : '0;
    wb_stb   <= 1'b1;
    wb_cyc   <= 1'b1;
    edges    = 0;
    ack_seen = 1'b0;
    while (!ack_seen) begin
      @(posedge wb_clk);
      edges++;
      @(negedge wb_clk);
      ack_seen = (wb_ack === 1'b1);
    end
    t.op   = op;
    t.adr  = adr;
    t.sel  = sel;
    t.wdat = dat;
    t.rdat = wb_dat_o;
    t.lat  = edges;
    // strobe drops on the edge that sees ack
    @(posedge wb_clk);
    wb_stb <= 1'b0;
    wb_cyc <= 1'b0;
    wb_we  <= 1'b0;
    if (op == OP_READ) begin
      reads_issued++;
    end
    txn_q.push_back(t);
    name_q.push_back(test_name);
  endtask

  // every finished cycle checked against the reference
  always @(negedge wb_clk) begin : compare_proc
    txn_t  t;
    string name;
    while (txn_q.size() > 0) begin
      t    = txn_q.pop_front();
      name = name_q.pop_front();
      check_latency(name, ACK_LATENCY, t.lat);
      if (t.op == OP_WRITE) begin
        ref_write(t.adr, t.sel, t.wdat);
      end else begin
        check_data(name, ref_read(t.adr), t.rdat);
        reads_checked++;
      end
    end
  end

  always @(posedge wb_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: the test did not complete within %0d clock cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $fatal(1, "simulation timed out");
    end
  end

  initial begin : stimulus
    logic [31:0]          r;
    logic [31:0]          r2;
    logic [ARRAY_AW-1:0]  dir_word [N_DIR_WORDS];
    logic [WB_ADDR_W-1:0] adr;
    logic [WB_SEL_W-1:0]  sel;
    zbt_op_e              op;
    int                   i;
    wb_dat_i = '0;
    wb_adr   = '0;
    wb_we    = 1'b0;
    wb_sel   = '0;
    wb_stb   = 1'b0;
    wb_cyc   = 1'b0;
    for (i = 0; i < REF_BYTES; i++) begin
      ref_bytes[i] = 8'h00;
    end
    @(posedge arst_n);
    repeat (2) @(posedge wb_clk);

    // ack must stay quiet with nothing requested
    test_name = "idle_after_reset";
    repeat (10) begin
      @(negedge wb_clk);
      check_ack(test_name, 1'b0, wb_ack);
    end
    test_name = "reset_read";
    run_bus_cycle(OP_READ, WB_ADDR_W'(13'h0155), 2'b11, '0);

    // both halves of a few words written then read back
    test_name = "full_word";
    for (i = 0; i < N_DIR_WORDS; i++) begin
      next_rand(r);
      next_rand(r2);
      dir_word[i] = r[ARRAY_AW-1:0];
      run_bus_cycle(OP_WRITE, WB_ADDR_W'({dir_word[i], 1'b0}), 2'b11, r2[15:0]);
      run_bus_cycle(OP_WRITE, WB_ADDR_W'({dir_word[i], 1'b1}), 2'b11, r2[31:16]);
      run_bus_cycle(OP_READ, WB_ADDR_W'({dir_word[i], 1'b0}), 2'b11, '0);
      run_bus_cycle(OP_READ, WB_ADDR_W'({dir_word[i], 1'b1}), 2'b11, '0);
    end

    // single byte lanes over known contents
    test_name = "byte_lane";
    for (i = 0; i < N_DIR_WORDS; i++) begin
      next_rand(r);
      run_bus_cycle(OP_WRITE, WB_ADDR_W'({dir_word[i], 1'b0}), 2'b01, r[15:0]);
      run_bus_cycle(OP_READ, WB_ADDR_W'({dir_word[i], 1'b0}), 2'b11, '0);
      run_bus_cycle(OP_WRITE, WB_ADDR_W'({dir_word[i], 1'b1}), 2'b10, r[31:16]);
      run_bus_cycle(OP_READ, WB_ADDR_W'({dir_word[i], 1'b1}), 2'b11, '0);
    end

    // random mix with half of it inside a small window so reads hit written data
    test_name = "random";
    for (i = 0; i < N_RANDOM; i++) begin
      next_rand(r);
      next_rand(r2);
      op  = r[0] ? OP_WRITE : OP_READ;
      sel = (r[2:1] == 2'b00) ? 2'b11 : r[2:1];
      adr = r[4] ? WB_ADDR_W'(r[31:19]) : WB_ADDR_W'(r[10:5]);
      run_bus_cycle(op, adr, sel, r2[15:0]);
    end

    repeat (4) @(posedge wb_clk);
    if ((txn_q.size() == 0) && (reads_checked == reads_issued)) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("Only %0d of %0d reads were checked", reads_checked, reads_issued);
      $display("TEST FAILED");
      $fatal(1, "incomplete checking");
    end
  end

endmodule
